//--- lzc.sv
// lzc: leading or trailing zero counter built as a priority tree
`timescale 1ns/1ps

module lzc #(
    parameter int unsigned WIDTH = 32,
    // 0 counts trailing zeros, 1 counts leading zeros
    parameter bit          MODE  = 1'b0
) (
    input  logic [WIDTH-1:0]         in_i,
    output logic [$clog2(WIDTH)-1:0] cnt_o,
    output logic                     empty_o
);
    localparam int unsigned LEVELS = $clog2(WIDTH);
    // tree is balanced, so leaves are padded up to a power of two
    localparam int unsigned LEAVES = 2 ** LEVELS;
    localparam int unsigned NODES  = 2 * LEAVES - 1;

    // heap numbering, node n has children 2n+1 and 2n+2
    logic              vld_node [NODES];
    logic [LEVELS-1:0] idx_node [NODES];

    always_comb begin
        // leaves sit at the bottom of the heap
        for (int k = 0; k < LEAVES; k++) begin
            idx_node[LEAVES-1+k] = LEVELS'(k);
            if (k < WIDTH) begin
                // leading mode scans from the msb, so the input is mirrored
                vld_node[LEAVES-1+k] = MODE ? in_i[WIDTH-1-k] : in_i[k];
            end else begin
                vld_node[LEAVES-1+k] = 1'b0;
            end
        end
        // walk upwards, the lower index child wins
        for (int n = LEAVES - 2; n >= 0; n--) begin
            vld_node[n] = vld_node[2*n+1] | vld_node[2*n+2];
            if (vld_node[2*n+1]) begin
                idx_node[n] = idx_node[2*n+1];
            end else begin
                idx_node[n] = idx_node[2*n+2];
            end
        end
    end

    // count is only meaningful when some bit is set
    assign empty_o = ~vld_node[0];
    assign cnt_o   = empty_o ? '0 : idx_node[0];

endmodule

//--- pmp_cfg_regs.sv
// pmp_cfg_regs: pmpcfg and pmpaddr register bank with lock rules and read-back
`timescale 1ns/1ps

module pmp_cfg_regs #(
    parameter int unsigned PMP_LEN    = 32,
    parameter int unsigned NR_ENTRIES = 8,
    // index width, at least one bit
    localparam int unsigned IDX_W     = (NR_ENTRIES > 1) ? $clog2(NR_ENTRIES) : 1
) (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    // pmpcfg byte write
    input  logic                            cfg_we_i,
    input  logic [IDX_W-1:0]                cfg_idx_i,
    input  logic [7:0]                      cfg_wdata_i,
    // pmpaddr write
    input  logic                            addr_we_i,
    input  logic [IDX_W-1:0]                addr_idx_i,
    input  logic [PMP_LEN-1:0]              addr_wdata_i,
    // read-back
    input  logic [IDX_W-1:0]                rd_idx_i,
    output logic [7:0]                      cfg_rdata_o,
    output logic [PMP_LEN-1:0]              addr_rdata_o,
    // flat views for the checker
    output logic [8*NR_ENTRIES-1:0]         cfg_o,
    output logic [NR_ENTRIES*PMP_LEN-1:0]   pmpaddr_o
);
    logic [7:0]         cfg_q  [NR_ENTRIES];
    logic [PMP_LEN-1:0] addr_q [NR_ENTRIES];

    logic [NR_ENTRIES-1:0] cfg_locked;
    logic [NR_ENTRIES-1:0] addr_locked;

    always_comb begin
        for (int i = 0; i < NR_ENTRIES; i++) begin
            cfg_locked[i]  = cfg_q[i][pmp_pkg::CFG_L];
            addr_locked[i] = cfg_q[i][pmp_pkg::CFG_L];
            // a locked TOR entry above also guards this entry's address
            if (i + 1 < NR_ENTRIES) begin
                if (cfg_q[i+1][pmp_pkg::CFG_L] &&
                    pmp_pkg::pmp_addr_mode_t'(cfg_q[i+1][pmp_pkg::CFG_A_HI:pmp_pkg::CFG_A_LO])
                        == pmp_pkg::TOR) begin
                    addr_locked[i] = 1'b1;
                end
            end
        end
    end

    // indices beyond NR_ENTRIES hit no register and are dropped
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NR_ENTRIES; i++) begin
                cfg_q[i]  <= '0;
                addr_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NR_ENTRIES; i++) begin
                if (cfg_we_i && cfg_idx_i == IDX_W'(i) && !cfg_locked[i]) begin
                    // reserved bits 6:5 are cleared on write
                    cfg_q[i] <= cfg_wdata_i & pmp_pkg::CFG_WMASK;
                end
                if (addr_we_i && addr_idx_i == IDX_W'(i) && !addr_locked[i]) begin
                    addr_q[i] <= addr_wdata_i;
                end
            end
        end
    end

    // read mux, unused indices return zero
    always_comb begin
        cfg_rdata_o  = '0;
        addr_rdata_o = '0;
        for (int i = 0; i < NR_ENTRIES; i++) begin
            if (rd_idx_i == IDX_W'(i)) begin
                cfg_rdata_o  = cfg_q[i];
                addr_rdata_o = addr_q[i];
            end
        end
    end

    for (genvar i = 0; i < NR_ENTRIES; i++) begin : g_flat
        assign cfg_o[8*i +: 8]                = cfg_q[i];
        assign pmpaddr_o[i*PMP_LEN +: PMP_LEN] = addr_q[i];

        // once locked, a byte stays as it is until reset
        a_lock_stable : assert property (
            @(posedge clk_i) disable iff (!arst_n_i)
            cfg_q[i][pmp_pkg::CFG_L] |=> $stable(cfg_q[i])
        ) else $error("pmp_cfg_regs: locked pmpcfg byte %0d changed", i);
    end

endmodule

//--- pmp_checker.sv
// pmp_checker: all PMP entries, lowest-index match selection and permission check
`timescale 1ns/1ps

module pmp_checker #(
    parameter int unsigned PLEN       = 34,
    parameter int unsigned PMP_LEN    = 32,
    parameter int unsigned NR_ENTRIES = 8
) (
    // clock and reset only sample the assertion
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic [PLEN-1:0]                 addr_i,
    input  pmp_pkg::access_t                type_i,
    input  pmp_pkg::priv_lvl_t              priv_i,
    // one byte per entry, entry 0 in the low byte
    input  logic [8*NR_ENTRIES-1:0]         cfg_i,
    input  logic [NR_ENTRIES*PMP_LEN-1:0]   pmpaddr_i,
    output logic                            allow_o
);
    logic [NR_ENTRIES-1:0] match;
    logic                  any_match;
    logic [7:0]            win_cfg;
    logic                  perm;
    logic [NR_ENTRIES-1:0] first_hit;
    logic [7:0]            first_cfg;

    for (genvar i = 0; i < NR_ENTRIES; i++) begin : g_entry
        logic [PMP_LEN-1:0] prev_addr;

        // entry 0 has zero as its TOR lower bound
        if (i == 0) begin : g_first
            assign prev_addr = '0;
        end else begin : g_rest
            assign prev_addr = pmpaddr_i[(i-1)*PMP_LEN +: PMP_LEN];
        end

        pmp_entry #(
            .PLEN    (PLEN),
            .PMP_LEN (PMP_LEN)
        ) i_entry (
            .addr_i           (addr_i),
            .conf_addr_i      (pmpaddr_i[i*PMP_LEN +: PMP_LEN]),
            .conf_addr_prev_i (prev_addr),
            .conf_addr_mode_i (pmp_pkg::pmp_addr_mode_t'(
                                   cfg_i[8*i+pmp_pkg::CFG_A_HI : 8*i+pmp_pkg::CFG_A_LO])),
            .match_o          (match[i])
        );
    end

    // scan from the top so the lowest matching index is kept last
    always_comb begin
        any_match = 1'b0;
        win_cfg   = '0;
        for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                any_match = 1'b1;
                win_cfg   = cfg_i[8*i +: 8];
            end
        end
    end

    // permission bit of the winner for this access kind
    always_comb begin
        case (type_i)
            pmp_pkg::ACC_READ:  perm = win_cfg[pmp_pkg::CFG_R];
            pmp_pkg::ACC_WRITE: perm = win_cfg[pmp_pkg::CFG_W];
            pmp_pkg::ACC_EXEC:  perm = win_cfg[pmp_pkg::CFG_X];
            default:            perm = 1'b0;
        endcase
    end

    always_comb begin
        if (!any_match) begin
            // no hit, only machine mode passes
            allow_o = (priv_i == pmp_pkg::PRIV_M);
        end else if (priv_i == pmp_pkg::PRIV_M && !win_cfg[pmp_pkg::CFG_L]) begin
            // M mode is bound only by locked entries
            allow_o = 1'b1;
        end else begin
            allow_o = perm;
        end
    end

    // lowest set bit of the match vector, isolated with the two's complement
    assign first_hit = match & (~match + NR_ENTRIES'(1));

    // byte of that entry, picked with a one-hot select
    always_comb begin
        first_cfg = '0;
        for (int i = 0; i < NR_ENTRIES; i++) begin
            if (first_hit[i]) begin
                first_cfg = first_cfg | cfg_i[8*i +: 8];
            end
        end
    end

    // the priority scan has to land on the lowest matching entry
    a_lowest_wins : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (match != '0) |-> (any_match && (win_cfg == first_cfg))
    ) else $error("pmp_checker: decision not taken from the lowest matching entry");

endmodule

//--- pmp_entry.sv
// pmp_entry: address match of one PMP entry in OFF, TOR, NA4 and NAPOT modes
`timescale 1ns/1ps

module pmp_entry #(
    parameter int unsigned PLEN    = 34,
    parameter int unsigned PMP_LEN = 32
) (
    // physical address of the access
    input  logic [PLEN-1:0]              addr_i,
    // this entry's pmpaddr and the one below it
    input  logic [PMP_LEN-1:0]           conf_addr_i,
    input  logic [PMP_LEN-1:0]           conf_addr_prev_i,
    input  pmp_pkg::pmp_addr_mode_t      conf_addr_mode_i,
    output logic                         match_o
);
    // wide enough for PMP_LEN + 3
    localparam int unsigned SW = $clog2(PMP_LEN + 4) + 1;

    logic [PMP_LEN-1:0]         conf_addr_n;
    logic [$clog2(PMP_LEN)-1:0] trail_ones;
    logic                       all_ones;
    logic [PLEN-1:0]            lo_bound;
    logic [PLEN-1:0]            hi_bound;
    logic [PLEN-1:0]            mask;
    logic [PLEN-1:0]            base;
    logic [SW-1:0]              size;

    // trailing ones of pmpaddr are the trailing zeros of its inverse
    assign conf_addr_n = ~conf_addr_i;

    lzc #(
        .WIDTH (PMP_LEN),
        .MODE  (1'b0)
    ) i_lzc (
        .in_i    (conf_addr_n),
        .cnt_o   (trail_ones),
        .empty_o (all_ones)
    );

    // pmpaddr holds byte address bits PLEN-1:2
    assign lo_bound = PLEN'({conf_addr_prev_i, 2'b00});
    assign hi_bound = PLEN'({conf_addr_i, 2'b00});

    always_comb begin
        size    = '0;
        mask    = '0;
        base    = '0;
        match_o = 1'b0;
        case (conf_addr_mode_i)
            pmp_pkg::TOR: begin
                // half-open range, empty when prev >= conf
                match_o = (addr_i >= lo_bound) && (addr_i < hi_bound);
            end
            pmp_pkg::NA4, pmp_pkg::NAPOT: begin
                if (conf_addr_mode_i == pmp_pkg::NA4) begin
                    size = SW'(2);
                end else if (all_ones) begin
                    // all ones covers the whole address space
                    size = SW'(PMP_LEN + 3);
                end else begin
                    size = SW'(trail_ones) + SW'(3);
                end
                // regions at least as large as the address space match everything
                if (size >= SW'(PLEN)) begin
                    mask = '0;
                end else begin
                    mask = {PLEN{1'b1}} << size;
                end
                base    = hi_bound & mask;
                match_o = (addr_i & mask) == base;
            end
            default: begin
                // OFF never matches
                match_o = 1'b0;
            end
        endcase
    end

endmodule

//--- pmp_pkg.sv
// pmp_pkg: address-mode, access-type and privilege enums, pmpcfg byte field positions
package pmp_pkg;

    // A field of a pmpcfg byte
    // OFF disables the entry, TOR uses the previous pmpaddr as lower bound
    typedef enum logic [1:0] {
        OFF   = 2'b00,
        TOR   = 2'b01,
        NA4   = 2'b10,
        NAPOT = 2'b11
    } pmp_addr_mode_t;

    // kind of physical access being checked
    typedef enum logic [1:0] {
        ACC_READ  = 2'b00,
        ACC_WRITE = 2'b01,
        ACC_EXEC  = 2'b10
    } access_t;

    // privilege level of the requester, encoding as in the privileged spec
    // (2'b10 is reserved and never issued)
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01,
        PRIV_M = 2'b11
    } priv_lvl_t;

    // bit positions inside one pmpcfg byte
    // read permission
    localparam int unsigned CFG_R    = 0;
    // write permission
    localparam int unsigned CFG_W    = 1;
    // execute permission
    localparam int unsigned CFG_X    = 2;
    // address matching mode, two bits wide
    localparam int unsigned CFG_A_LO = 3;
    localparam int unsigned CFG_A_HI = 4;
    // lock bit, also restricts machine mode
    localparam int unsigned CFG_L    = 7;

    // writable bits of a pmpcfg byte
    // bits 6:5 are reserved and always read as zero
    localparam logic [7:0] CFG_WMASK = 8'h9f;

endpackage

//--- pmp_top.sv
// pmp_top: PMP register bank, checker and registered check result
`timescale 1ns/1ps

module pmp_top #(
    parameter int unsigned PLEN       = 34,
    parameter int unsigned PMP_LEN    = 32,
    parameter int unsigned NR_ENTRIES = 8,
    localparam int unsigned IDX_W     = (NR_ENTRIES > 1) ? $clog2(NR_ENTRIES) : 1
) (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    // register write port
    input  logic                    cfg_we_i,
    input  logic [IDX_W-1:0]        cfg_idx_i,
    input  logic [7:0]              cfg_wdata_i,
    input  logic                    addr_we_i,
    input  logic [IDX_W-1:0]        addr_idx_i,
    input  logic [PMP_LEN-1:0]      addr_wdata_i,
    // read-back port
    input  logic [IDX_W-1:0]        rd_idx_i,
    output logic [7:0]              cfg_rdata_o,
    output logic [PMP_LEN-1:0]      addr_rdata_o,
    // check request
    input  logic                    check_valid_i,
    input  logic [PLEN-1:0]         check_addr_i,
    input  pmp_pkg::access_t        check_type_i,
    input  pmp_pkg::priv_lvl_t      check_priv_i,
    // check result, one cycle later
    output logic                    check_valid_o,
    output logic                    allow_o
);
    logic [8*NR_ENTRIES-1:0]       cfg;
    logic [NR_ENTRIES*PMP_LEN-1:0] pmpaddr;
    logic                          allow_comb;

    pmp_cfg_regs #(
        .PMP_LEN    (PMP_LEN),
        .NR_ENTRIES (NR_ENTRIES)
    ) i_regs (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .cfg_we_i     (cfg_we_i),
        .cfg_idx_i    (cfg_idx_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .addr_we_i    (addr_we_i),
        .addr_idx_i   (addr_idx_i),
        .addr_wdata_i (addr_wdata_i),
        .rd_idx_i     (rd_idx_i),
        .cfg_rdata_o  (cfg_rdata_o),
        .addr_rdata_o (addr_rdata_o),
        .cfg_o        (cfg),
        .pmpaddr_o    (pmpaddr)
    );

    // decision is combinational on the current register state
    pmp_checker #(
        .PLEN       (PLEN),
        .PMP_LEN    (PMP_LEN),
        .NR_ENTRIES (NR_ENTRIES)
    ) i_checker (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .addr_i    (check_addr_i),
        .type_i    (check_type_i),
        .priv_i    (check_priv_i),
        .cfg_i     (cfg),
        .pmpaddr_i (pmpaddr),
        .allow_o   (allow_comb)
    );

    // result strobe, allow held low when no check is pending
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            check_valid_o <= 1'b0;
            allow_o       <= 1'b0;
        end else begin
            check_valid_o <= check_valid_i;
            allow_o       <= check_valid_i & allow_comb;
        end
    end

endmodule

//--- src.f
pmp_pkg.sv
lzc.sv
pmp_entry.sv
pmp_checker.sv
pmp_cfg_regs.sv
pmp_top.sv
tb_clkgen.sv
tb_pmp_top.sv

//--- tb_clkgen.sv
// tb_clkgen: testbench clock and active-low reset generator
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int unsigned PERIOD_NS  = 40,
    parameter int unsigned RST_CYCLES = 8
) (
    output logic clk_o,
    output logic arst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // reset let go a little after an edge, away from the sampling point
    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #2;
        arst_n_o = 1'b1;
    end

endmodule

//--- tb_pmp_top.sv
// tb_pmp_top: PMP testbench with shadow register model, reference decision, stimulus and checks
`timescale 1ns/1ps

module tb_pmp_top;
    localparam int unsigned PLEN       = 34;
    localparam int unsigned PMP_LEN    = 32;
    localparam int unsigned NR_ENTRIES = 8;
    localparam int unsigned IDX_W      = 3;

    logic                 clk_i;
    logic                 arst_n_i;
    logic                 cfg_we_i;
    logic [IDX_W-1:0]     cfg_idx_i;
    logic [7:0]           cfg_wdata_i;
    logic                 addr_we_i;
    logic [IDX_W-1:0]     addr_idx_i;
    logic [PMP_LEN-1:0]   addr_wdata_i;
    logic [IDX_W-1:0]     rd_idx_i;
    logic [7:0]           cfg_rdata_o;
    logic [PMP_LEN-1:0]   addr_rdata_o;
    logic                 check_valid_i;
    logic [PLEN-1:0]      check_addr_i;
    pmp_pkg::access_t     check_type_i;
    pmp_pkg::priv_lvl_t   check_priv_i;
    logic                 check_valid_o;
    logic                 allow_o;

    // shadow copy of the register bank
    logic [7:0]         m_cfg  [NR_ENTRIES];
    logic [PMP_LEN-1:0] m_addr [NR_ENTRIES];

    // outstanding checks in issue order
    bit              exp_allow_q [$];
    int              exp_cycle_q [$];
    logic [PLEN-1:0] exp_addr_q  [$];

    int unsigned rng_state    = 42;
    int          cycle_cnt    = 0;
    int          err_cnt      = 0;
    int          test_err0    = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    string       test_name;

    tb_clkgen #(
        .PERIOD_NS  (40),
        .RST_CYCLES (8)
    ) clkgen (
        .clk_o    (clk_i),
        .arst_n_o (arst_n_i)
    );

    pmp_top #(
        .PLEN       (PLEN),
        .PMP_LEN    (PMP_LEN),
        .NR_ENTRIES (NR_ENTRIES)
    ) dut (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .cfg_we_i      (cfg_we_i),
        .cfg_idx_i     (cfg_idx_i),
        .cfg_wdata_i   (cfg_wdata_i),
        .addr_we_i     (addr_we_i),
        .addr_idx_i    (addr_idx_i),
        .addr_wdata_i  (addr_wdata_i),
        .rd_idx_i      (rd_idx_i),
        .cfg_rdata_o   (cfg_rdata_o),
        .addr_rdata_o  (addr_rdata_o),
        .check_valid_i (check_valid_i),
        .check_addr_i  (check_addr_i),
        .check_type_i  (check_type_i),
        .check_priv_i  (check_priv_i),
        .check_valid_o (check_valid_o),
        .allow_o       (allow_o)
    );

    // cycle number, used to time the result strobe
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic pmp_pkg::priv_lvl_t priv_of(int n);
        case (n % 3)
            0:       return pmp_pkg::PRIV_U;
            1:       return pmp_pkg::PRIV_S;
            default: return pmp_pkg::PRIV_M;
        endcase
    endfunction

    // expected decision from the shadow registers
    function automatic bit ref_allow(logic [PLEN-1:0] a, pmp_pkg::access_t t,
                                     pmp_pkg::priv_lvl_t p);
        logic [PLEN-1:0] lo;
        logic [PLEN-1:0] hi;
        int              ones;
        bit              hit;
        for (int i = 0; i < NR_ENTRIES; i++) begin
            lo  = '0;
            hit = 1'b0;
            if (i > 0) begin
                lo = {m_addr[i-1], 2'b00};
            end
            hi = {m_addr[i], 2'b00};
            case (m_cfg[i][4:3])
                2'd1: hit = (a >= lo) && (a < hi);
                2'd2: hit = (a[PLEN-1:2] == m_addr[i]);
                2'd3: begin
                    ones = 0;
                    while (ones < PMP_LEN && m_addr[i][ones]) begin
                        ones++;
                    end
                    // region of 2^(ones+3) bytes
                    hit = (ones + 3 >= PLEN) || ((a >> (ones + 3)) == (hi >> (ones + 3)));
                end
                default: hit = 1'b0;
            endcase
            if (hit) begin
                if (p == pmp_pkg::PRIV_M && !m_cfg[i][7]) begin
                    return 1'b1;
                end
                case (t)
                    pmp_pkg::ACC_READ:  return m_cfg[i][0];
                    pmp_pkg::ACC_WRITE: return m_cfg[i][1];
                    default:            return m_cfg[i][2];
                endcase
            end
        end
        // nothing matched, only machine mode passes
        return p == pmp_pkg::PRIV_M;
    endfunction

    // address around entry j, low bits flipped at random
    function automatic logic [PLEN-1:0] addr_near(int j);
        logic [31:0]     r;
        logic [PLEN-1:0] base;
        r    = lcg_next();
        base = {m_addr[j], 2'b00};
        return base ^ (PLEN'(lcg_next()) & ((PLEN'(1) << (r % 20)) - 1));
    endfunction

    task automatic check_allow(input logic got, input bit exp, input string what);
        if (got !== exp) begin
            $display("FAILED t=%0t %s: got %b, expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_cfg(input logic [7:0] got, input logic [7:0] exp, input int idx);
        if (got !== exp) begin
            $display("FAILED t=%0t pmpcfg%0d read-back: got 0x%02h, expected 0x%02h",
                     $time, idx, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_addr(input logic [PMP_LEN-1:0] got, input logic [PMP_LEN-1:0] exp,
                              input int idx);
        if (got !== exp) begin
            $display("FAILED t=%0t pmpaddr%0d read-back: got 0x%08h, expected 0x%08h",
                     $time, idx, got, exp);
            err_cnt++;
        end
    endtask

    // compare each result strobe with the oldest outstanding check
    initial begin : compare_results
        bit              e;
        int              c;
        logic [PLEN-1:0] a;
        forever begin
            @(negedge clk_i);
            if (check_valid_o) begin
                if (exp_allow_q.size() == 0) begin
                    $display("unexpected result strobe at %0t with no check pending", $time);
                    err_cnt++;
                end else begin
                    e = exp_allow_q.pop_front();
                    c = exp_cycle_q.pop_front();
                    a = exp_addr_q.pop_front();
                    if (c != cycle_cnt) begin
                        $display("result strobe for 0x%0h came in cycle %0d, expected %0d",
                                 a, cycle_cnt, c);
                        err_cnt++;
                    end
                    check_allow(allow_o, e, $sformatf("allow for addr 0x%0h", a));
                end
            end else if (exp_cycle_q.size() > 0 && exp_cycle_q[0] <= cycle_cnt) begin
                $display("result strobe missing for check of 0x%0h at %0t", exp_addr_q[0], $time);
                err_cnt++;
                void'(exp_allow_q.pop_front());
                void'(exp_cycle_q.pop_front());
                void'(exp_addr_q.pop_front());
            end
        end
    end

    // next drive slot, 2 ns after the edge, strobes dropped
    task automatic step();
        @(posedge clk_i);
        #2;
        cfg_we_i      = 1'b0;
        addr_we_i     = 1'b0;
        check_valid_i = 1'b0;
    endtask

    task automatic write_cfg(input int idx, input logic [7:0] data);
        step();
        cfg_we_i    = 1'b1;
        cfg_idx_i   = IDX_W'(idx);
        cfg_wdata_i = data;
        // locked byte keeps its value, bits 6:5 never stored
        if (!m_cfg[idx][7]) begin
            m_cfg[idx] = data & 8'h9f;
        end
    endtask

    task automatic write_addr(input int idx, input logic [PMP_LEN-1:0] data);
        bit locked;
        step();
        addr_we_i    = 1'b1;
        addr_idx_i   = IDX_W'(idx);
        addr_wdata_i = data;
        locked = m_cfg[idx][7];
        // TOR entry above, when locked, guards this address as its base
        if (idx + 1 < NR_ENTRIES && m_cfg[idx+1][7] && m_cfg[idx+1][4:3] == 2'd1) begin
            locked = 1'b1;
        end
        if (!locked) begin
            m_addr[idx] = data;
        end
    endtask

    task automatic clear_all();
        for (int i = 0; i < NR_ENTRIES; i++) begin
            write_cfg(i, 8'h00);
            write_addr(i, '0);
        end
    endtask

    task automatic issue_check(input logic [PLEN-1:0] a, input pmp_pkg::access_t t,
                               input pmp_pkg::priv_lvl_t p);
        step();
        check_valid_i = 1'b1;
        check_addr_i  = a;
        check_type_i  = t;
        check_priv_i  = p;
        exp_allow_q.push_back(ref_allow(a, t, p));
        exp_cycle_q.push_back(cycle_cnt + 1);
        exp_addr_q.push_back(a);
    endtask

    // every access type at every privilege level
    task automatic check_all_kinds(input logic [PLEN-1:0] a);
        for (int t = 0; t < 3; t++) begin
            for (int p = 0; p < 3; p++) begin
                issue_check(a, pmp_pkg::access_t'(2'(t)), priv_of(p));
            end
        end
    endtask

    task automatic read_check(input int idx);
        step();
        rd_idx_i = IDX_W'(idx);
        #1;
        check_cfg(cfg_rdata_o, m_cfg[idx], idx);
        check_addr(addr_rdata_o, m_addr[idx], idx);
    endtask

    task automatic wait_results();
        step();
        for (int n = 0; n < 50 && exp_allow_q.size() > 0; n++) begin
            @(posedge clk_i);
        end
        if (exp_allow_q.size() > 0) begin
            $display("timeout: %0d check results never arrived", exp_allow_q.size());
            err_cnt++;
            exp_allow_q.delete();
            exp_cycle_q.delete();
            exp_addr_q.delete();
        end
    endtask

    // reset may still be unknown at time zero, so wait for a clean high
    task automatic wait_reset();
        for (int n = 0; n < 20 && arst_n_i !== 1'b1; n++) begin
            @(posedge clk_i);
        end
        if (arst_n_i !== 1'b1) begin
            $display("timeout: reset was never released");
            err_cnt++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err0 = err_cnt;
        tests_run++;
    endtask

    task automatic end_test();
        wait_results();
        if (err_cnt == test_err0) begin
            $display("test %0d %s: passed", tests_run, test_name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, test_name,
                     err_cnt - test_err0);
        end
    endtask

    initial begin : stimulus
        logic [PLEN-1:0] tor_pts [7];
        logic [PLEN-1:0] a;
        logic [31:0]     r;
        int unsigned     sz;
        cfg_we_i      = 1'b0;
        cfg_idx_i     = '0;
        cfg_wdata_i   = '0;
        addr_we_i     = 1'b0;
        addr_idx_i    = '0;
        addr_wdata_i  = '0;
        rd_idx_i      = '0;
        check_valid_i = 1'b0;
        check_addr_i  = '0;
        check_type_i  = pmp_pkg::ACC_READ;
        check_priv_i  = pmp_pkg::PRIV_M;
        for (int i = 0; i < NR_ENTRIES; i++) begin
            m_cfg[i]  = '0;
            m_addr[i] = '0;
        end
        tor_pts = '{34'h0, 34'h3fc, 34'h3ff, 34'h400, 34'h7fc, 34'h7ff, 34'h800};
        wait_reset();

        begin_test("reset state");
        check_allow(check_valid_o, 1'b0, "check_valid_o after reset");
        check_allow(allow_o, 1'b0, "allow_o after reset");
        for (int i = 0; i < NR_ENTRIES; i++) begin
            read_check(i);
        end
        check_all_kinds(34'h1234);
        check_all_kinds(34'h3_ffff_fffc);
        end_test();

        begin_test("TOR bounds");
        clear_all();
        // entry 0 covers [0, 0x400) read only, entry 1 [0x400, 0x800) read/write
        write_addr(0, 32'h100);
        write_cfg(0, 8'h09);
        write_addr(1, 32'h200);
        write_cfg(1, 8'h0b);
        for (int k = 0; k < 7; k++) begin
            issue_check(tor_pts[k], pmp_pkg::ACC_READ, pmp_pkg::PRIV_S);
            issue_check(tor_pts[k], pmp_pkg::ACC_WRITE, pmp_pkg::PRIV_U);
            issue_check(tor_pts[k], pmp_pkg::ACC_EXEC, pmp_pkg::PRIV_M);
        end
        end_test();

        begin_test("NA4 and NAPOT regions");
        clear_all();
        // NA4 word at 0x4000, execute only
        write_addr(2, 32'h1000);
        write_cfg(2, 8'h14);
        for (int k = -4; k < 8; k += 2) begin
            issue_check(34'h4000 + k, pmp_pkg::ACC_EXEC, pmp_pkg::PRIV_S);
        end
        // NAPOT at 0x10000 with 8, 128 and 2048 bytes
        for (int k = 0; k < 12; k += 4) begin
            sz = 1 << (k + 3);
            write_addr(3, 32'h4000 | ((32'd1 << k) - 1));
            write_cfg(3, 8'h19);
            for (int n = 0; n < 6; n++) begin
                issue_check(34'h10000 + PLEN'(lcg_next() % sz), pmp_pkg::ACC_READ,
                            pmp_pkg::PRIV_S);
                issue_check(34'h10000 + sz + PLEN'(lcg_next() % sz), pmp_pkg::ACC_READ,
                            pmp_pkg::PRIV_S);
                issue_check(34'h10000 - 1 - PLEN'(lcg_next() % sz), pmp_pkg::ACC_READ,
                            pmp_pkg::PRIV_U);
            end
        end
        end_test();

        begin_test("priority and permissions");
        clear_all();
        // 4 KiB read-only window inside a 16 KiB write/exec region
        write_addr(0, 32'h81ff);
        write_cfg(0, 8'h19);
        write_addr(1, 32'h87ff);
        write_cfg(1, 8'h1e);
        check_all_kinds(34'h20010);
        check_all_kinds(34'h23000);
        check_all_kinds(34'h30000);
        end_test();

        begin_test("locks");
        clear_all();
        // entry 6 locked TOR [0x3000, 0x4000) read only
        write_addr(5, 32'hc00);
        write_addr(6, 32'h1000);
        write_cfg(6, 8'h89);
        write_addr(5, 32'h123);
        write_addr(6, 32'h2222);
        write_cfg(6, 8'h0f);
        // reserved bits dropped on an unlocked byte
        write_cfg(4, 8'h7f);
        // entry 7 locked NA4 with no permissions
        write_addr(7, 32'h14000);
        write_cfg(7, 8'h90);
        write_cfg(7, 8'h00);
        for (int i = 4; i < NR_ENTRIES; i++) begin
            read_check(i);
        end
        check_all_kinds(34'h3800);
        check_all_kinds(34'h2ffc);
        check_all_kinds(34'h50000);
        end_test();

        begin_test("random stream");
        for (int round = 0; round < 8; round++) begin
            for (int i = 0; i < NR_ENTRIES; i++) begin
                write_addr(i, lcg_next());
                r = lcg_next();
                // lock set only now and then
                write_cfg(i, {r[15:12] == 4'd0, r[6:0]});
            end
            // back to back, one check per cycle
            for (int n = 0; n < 40; n++) begin
                a = addr_near(int'(lcg_next() % NR_ENTRIES));
                r = lcg_next();
                issue_check(a, pmp_pkg::access_t'(2'(r % 3)), priv_of(int'(r[15:8])));
            end
            wait_results();
        end
        end_test();

        $display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 err_cnt);
        if (err_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
